//--- verilog/cpu_pkg.sv
// Instruction set constants, opcode enum and pipeline stage structs
package cpu_pkg;

    localparam int XLEN    = 16;  // Widest data path a stage may use
    localparam int PC_W    = 8;
    localparam int INSTR_W = 16;

    typedef logic [2:0] reg_idx_t;  // r0 reads as zero

    // Opcode in instr[15:12]
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_OR   = 4'h4,
        OP_XOR  = 4'h5,
        OP_ADDI = 4'h6,
        OP_LI   = 4'h7,
        OP_BEQZ = 4'h8
    } op_e;

    // Decode to execute
    typedef struct packed {
        logic            valid;
        logic [PC_W-1:0] pc;
        op_e             op;
        reg_idx_t        rd;
        reg_idx_t        rs;
        reg_idx_t        rt;
        logic [XLEN-1:0] rs_val;
        logic [XLEN-1:0] rt_val;
        logic [XLEN-1:0] imm;     // Sign-extended imm6
        logic            we;
    } dec_t;

    // Execute to result
    typedef struct packed {
        logic            valid;
        logic [PC_W-1:0] pc;
        reg_idx_t        rd;
        logic            we;
        logic [XLEN-1:0] value;
    } exe_t;

    // Write port back into the register file
    typedef struct packed {
        logic            en;
        reg_idx_t        rd;
        logic [XLEN-1:0] value;
    } wb_t;

endpackage

//--- verilog/trace_pkg.sv
// Trace tag and retirement record types
package trace_pkg;

    localparam int TAG_W = 16;  // Width of every stamped field

    // Follows one instruction down the pipe
    typedef struct packed {
        logic [TAG_W-1:0] seq;
        logic [TAG_W-1:0] fetch_cycle;
        logic [TAG_W-1:0] hold_cycles;  // Hold run just before acceptance
    } trace_tag_t;

    // One record per retired instruction
    typedef struct packed {
        trace_tag_t                  tag;
        logic [TAG_W-1:0]            retire_cycle;
        logic [cpu_pkg::PC_W-1:0]    pc;
        cpu_pkg::reg_idx_t           rd;
        logic                        we;
        logic [cpu_pkg::XLEN-1:0]    value;
    } trace_rec_t;

endpackage

//--- verilog/decode_stage.sv
// Program counter, fetch and decode register, register file with write-first bypass
`timescale 1ns/100ps

module decode_stage #(
    parameter int DATA_W = 16
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [cpu_pkg::INSTR_W-1:0] instr,
    input  logic                        hold,
    input  logic                        flush,
    input  logic [cpu_pkg::PC_W-1:0]    redirect_pc,
    input  cpu_pkg::wb_t                wb,
    output logic [cpu_pkg::PC_W-1:0]    pc,
    output cpu_pkg::dec_t               dec
);
    import cpu_pkg::*;

    op_e               op;
    reg_idx_t          rd;
    reg_idx_t          rs;
    reg_idx_t          rt;
    logic [DATA_W-1:0] imm;
    logic              we;
    logic [DATA_W-1:0] regs [8];

    // Register read where a same-cycle write wins
    function automatic logic [DATA_W-1:0] read_port(input reg_idx_t idx);
        logic [DATA_W-1:0] val;
        if (idx == '0)
            val = '0;
        else if (wb.en && wb.rd == idx)
            val = wb.value[DATA_W-1:0];
        else
            val = regs[idx];
        return val;
    endfunction

    //////////////////////////////////////////////////
    // Field decode
    //////////////////////////////////////////////////
    always_comb begin
        op  = op_e'(instr[15:12]);
        rd  = instr[11:9];
        rs  = instr[8:6];
        rt  = instr[5:3];
        imm = {{(DATA_W-6){instr[5]}}, instr[5:0]};
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LI: we = 1'b1;
            default: we = 1'b0;  // NOP, BEQZ and unused codes
        endcase
    end

    // Program counter
    always_ff @(posedge clk) begin
        if (rst)
            pc <= '0;
        else if (flush)
            pc <= redirect_pc;  // Taken branch wins over hold
        else if (!hold)
            pc <= pc + PC_W'(1);
    end

    // Decode register
    always_ff @(posedge clk) begin
        if (rst)
            dec.valid <= 1'b0;
        else
            dec.valid <= !hold && !flush;  // Bubble on hold or flush
        dec.pc     <= pc;
        dec.op     <= op;
        dec.rd     <= rd;
        dec.rs     <= rs;
        dec.rt     <= rt;
        dec.rs_val <= XLEN'(read_port(rs));
        dec.rt_val <= XLEN'(read_port(rt));
        dec.imm    <= XLEN'(imm);
        dec.we     <= we;
    end

    // Register file
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
        end else if (wb.en) begin
            regs[wb.rd] <= wb.value[DATA_W-1:0];  // Result stage drops r0 writes
        end
    end

    // r0 stays zero however the write port is driven
    reg0_zero: assert property (@(posedge clk) disable iff (rst) regs[0] == '0)
        else $error("register 0 holds a nonzero value");

endmodule

//--- verilog/execute_stage.sv
// Operand forwarding, ALU, branch resolution and redirect/flush generation
`timescale 1ns/100ps

module execute_stage #(
    parameter int DATA_W = 16
) (
    input  logic                     clk,
    input  logic                     rst,
    input  cpu_pkg::dec_t            dec,
    input  cpu_pkg::wb_t             wb,
    output cpu_pkg::exe_t            exe,
    output logic                     flush,
    output logic [cpu_pkg::PC_W-1:0] redirect_pc
);
    import cpu_pkg::*;

    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] imm;
    logic [DATA_W-1:0] alu_out;
    logic              taken;
    logic [PC_W-1:0]   target;

    // Youngest producer first, then write-back, then register file value
    function automatic logic [DATA_W-1:0] forward(input reg_idx_t idx,
                                                  input logic [DATA_W-1:0] rf_val);
        logic [DATA_W-1:0] val;
        if (idx != '0 && exe.valid && exe.we && exe.rd == idx)
            val = exe.value[DATA_W-1:0];  // One ahead
        else if (idx != '0 && wb.en && wb.rd == idx)
            val = wb.value[DATA_W-1:0];   // Two ahead
        else
            val = rf_val;
        return val;
    endfunction

    //////////////////////////////////////////////////
    // Operands and ALU
    //////////////////////////////////////////////////
    always_comb begin
        op_a = forward(dec.rs, dec.rs_val[DATA_W-1:0]);
        op_b = forward(dec.rt, dec.rt_val[DATA_W-1:0]);
        imm  = dec.imm[DATA_W-1:0];
        case (dec.op)
            OP_ADD:  alu_out = op_a + op_b;
            OP_SUB:  alu_out = op_a - op_b;
            OP_AND:  alu_out = op_a & op_b;
            OP_OR:   alu_out = op_a | op_b;
            OP_XOR:  alu_out = op_a ^ op_b;
            OP_ADDI: alu_out = op_a + imm;
            OP_LI:   alu_out = imm;
            default: alu_out = '0;  // NOP and BEQZ
        endcase
    end

    // Branch resolution, offset counted in instructions
    always_comb begin
        target = dec.pc + PC_W'(1) + dec.imm[PC_W-1:0];
        taken  = dec.valid && !flush && dec.op == OP_BEQZ && op_a == '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exe.valid <= 1'b0;
            flush     <= 1'b0;
        end else begin
            exe.valid <= dec.valid && !flush;  // Kill the one behind a taken branch
            flush     <= taken;
        end
        exe.pc      <= dec.pc;
        exe.rd      <= dec.rd;
        exe.we      <= dec.we;
        exe.value   <= XLEN'(alu_out);
        redirect_pc <= target;
    end

    // The resolving BEQZ sits in the execute register during its flush
    flush_src: assert property (@(posedge clk) disable iff (rst)
        flush |-> exe.valid && !exe.we)
        else $error("flush without a valid BEQZ in execute");

endmodule

//--- verilog/result_stage.sv
// Write-back register and retirement strobe
`timescale 1ns/100ps

module result_stage #(
    parameter int DATA_W = 16
) (
    input  logic                     clk,
    input  logic                     rst,
    input  cpu_pkg::exe_t            exe,
    output cpu_pkg::wb_t             wb,
    output logic                     retire_valid,
    output logic [cpu_pkg::PC_W-1:0] retire_pc,
    output cpu_pkg::reg_idx_t        retire_rd,
    output logic                     retire_we,
    output logic [cpu_pkg::XLEN-1:0] retire_value
);
    import cpu_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb.en        <= 1'b0;
            retire_valid <= 1'b0;
        end else begin
            wb.en        <= exe.valid && exe.we && exe.rd != '0;  // r0 never written
            retire_valid <= exe.valid;  // Branches and NOPs retire too
        end
        wb.rd     <= exe.rd;
        wb.value  <= XLEN'(exe.value[DATA_W-1:0]);
        retire_pc <= exe.pc;
    end

    // Retirement view of the write port
    assign retire_rd    = wb.rd;
    assign retire_we    = wb.en;
    assign retire_value = wb.value;

endmodule

//--- verilog/pipe_trace.sv
// Pipeline trace with stage tags, cycle, hold and flush counters, retirement record
`timescale 1ns/100ps

module pipe_trace #(
    parameter int CNT_W = 16
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     hold,
    input  logic                     flush,
    input  logic                     fetch_valid,   // Decode register valid
    input  logic                     retire_valid,
    input  logic [cpu_pkg::PC_W-1:0] retire_pc,
    input  cpu_pkg::reg_idx_t        retire_rd,
    input  logic                     retire_we,
    input  logic [cpu_pkg::XLEN-1:0] retire_value,
    output logic                     retire_out_valid,
    output trace_pkg::trace_rec_t    retire,
    output logic [CNT_W-1:0]         flush_count
);
    import trace_pkg::*;

    logic [CNT_W-1:0] cycle_cnt;
    logic [CNT_W-1:0] seq_cnt;     // Next sequence number
    logic [CNT_W-1:0] hold_run;
    logic [TAG_W-1:0] snap_cycle;  // Stamps of the cycle before
    logic [TAG_W-1:0] snap_hold;
    trace_tag_t       d_tag;
    trace_tag_t       e_tag;
    trace_tag_t       r_tag;
    logic             e_valid;
    logic             r_valid;

    //////////////////////////////////////////////////
    // Counters
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_cnt   <= '0;
            seq_cnt     <= '0;
            hold_run    <= '0;
            flush_count <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + CNT_W'(1);
            if (fetch_valid)
                seq_cnt <= seq_cnt + CNT_W'(1);
            hold_run <= hold ? hold_run + CNT_W'(1) : '0;
            if (flush)
                flush_count <= flush_count + CNT_W'(2);  // Decode and fetch slots lost
        end
        snap_cycle <= TAG_W'(cycle_cnt);
        snap_hold  <= TAG_W'(hold_run);
    end

    // Tag of the instruction now in decode as stamped in its fetch cycle
    always_comb begin
        d_tag.seq         = TAG_W'(seq_cnt);
        d_tag.fetch_cycle = snap_cycle;
        d_tag.hold_cycles = snap_hold;
    end

    //////////////////////////////////////////////////
    // Tag shift through execute and result
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            e_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            e_valid <= fetch_valid && !flush;  // Flush clears decode slot
            r_valid <= e_valid;
        end
        e_tag <= d_tag;
        r_tag <= e_tag;
    end

    // Record joins the result tag with the retiring data
    assign retire_out_valid = retire_valid;

    always_comb begin
        retire.tag          = r_tag;
        retire.retire_cycle = TAG_W'(cycle_cnt);
        retire.pc           = retire_pc;
        retire.rd           = retire_rd;
        retire.we           = retire_we;
        retire.value        = retire_value;
    end

    retire_tagged: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> r_valid)
        else $error("retirement without a result-slot tag");

    // Retiring instruction sat in decode two cycles earlier
    retire_latency: assert property (@(posedge clk) disable iff (rst)
        retire_out_valid |-> $past(fetch_valid, 2))
        else $error("retire cycle minus fetch cycle is not 3");

endmodule

//--- verilog/cpu_top.sv
// Core top level with decode, execute and result stages and the trace unit
`timescale 1ns/100ps

module cpu_top #(
    parameter int DATA_W = 16,
    parameter int CNT_W  = 16
) (
    input  logic                        clk,
    input  logic                        rst,
    output logic [cpu_pkg::PC_W-1:0]    pc,
    input  logic [cpu_pkg::INSTR_W-1:0] instr,  // Combinational read of pc
    input  logic                        hold,
    output logic                        flush,
    output logic                        retire_valid,
    output trace_pkg::trace_rec_t       retire,
    output logic [CNT_W-1:0]            flush_count
);
    import cpu_pkg::*;

    dec_t            dec;
    exe_t            exe;
    wb_t             wb;
    logic [PC_W-1:0] redirect_pc;

    // Raw retirement from the result stage
    logic            res_valid;
    logic [PC_W-1:0] res_pc;
    reg_idx_t        res_rd;
    logic            res_we;
    logic [XLEN-1:0] res_value;

    decode_stage #(.DATA_W(DATA_W)) u_decode (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .hold        (hold),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .wb          (wb),
        .pc          (pc),
        .dec         (dec)
    );

    execute_stage #(.DATA_W(DATA_W)) u_execute (
        .clk         (clk),
        .rst         (rst),
        .dec         (dec),
        .wb          (wb),
        .exe         (exe),
        .flush       (flush),
        .redirect_pc (redirect_pc)
    );

    result_stage #(.DATA_W(DATA_W)) u_result (
        .clk          (clk),
        .rst          (rst),
        .exe          (exe),
        .wb           (wb),
        .retire_valid (res_valid),
        .retire_pc    (res_pc),
        .retire_rd    (res_rd),
        .retire_we    (res_we),
        .retire_value (res_value)
    );

    pipe_trace #(.CNT_W(CNT_W)) u_trace (
        .clk              (clk),
        .rst              (rst),
        .hold             (hold),
        .flush            (flush),
        .fetch_valid      (dec.valid),
        .retire_valid     (res_valid),
        .retire_pc        (res_pc),
        .retire_rd        (res_rd),
        .retire_we        (res_we),
        .retire_value     (res_value),
        .retire_out_valid (retire_valid),
        .retire           (retire),
        .flush_count      (flush_count)
    );

endmodule

//--- sim/cpu_tb.sv
// Core testbench with clock, reset, program ROM, retirement table, fetch model and field checks
`timescale 1ns/100ps

module cpu_tb;
    import cpu_pkg::*;
    import trace_pkg::*;

    localparam int RETIRE_TIMEOUT = 50;  // Cycles per retirement
    localparam int RESET_TIMEOUT  = 10;

    // One expected retirement
    typedef struct packed {
        logic [7:0]  pc;
        logic [2:0]  rd;
        logic        we;
        logic [15:0] value;
    } expect_t;

    logic                  clk;
    logic                  rst;
    logic [7:0]            pc;
    logic [15:0]           instr;
    logic                  hold;
    logic                  flush;
    logic                  retire_valid;
    trace_rec_t            retire;
    logic [15:0]           flush_count;

    logic [15:0] rom [256];
    expect_t     expect_tbl [$];
    integer      seed;

    // Fetch model state
    int   exp_seq   [64];
    int   exp_fetch [64];
    int   exp_hold  [64];
    int   cyc;
    int   accepted;      // Sequence numbers handed out
    int   hold_run;
    int   flush_cyc;
    int   flush_target;
    int   pc_model;
    int   nxt;           // Next table entry to be fetched
    logic flush_now;

    cpu_top #(.DATA_W(16), .CNT_W(16)) DUT (
        .clk          (clk),
        .rst          (rst),
        .pc           (pc),
        .instr        (instr),
        .hold         (hold),
        .flush        (flush),
        .retire_valid (retire_valid),
        .retire       (retire),
        .flush_count  (flush_count)
    );

    assign instr = rom[pc];  // Combinational program ROM

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
            fail_run($sformatf("Fail at %0d ns: %s is 0x%0h, expected 0x%0h",
                               $time, name, got, expected));
    endtask

    function automatic logic [15:0] encode_reg(input op_e op, input reg_idx_t rd,
                                               input reg_idx_t rs, input reg_idx_t rt);
        return {op, rd, rs, rt, 3'b000};
    endfunction

    function automatic logic [15:0] encode_imm(input op_e op, input reg_idx_t rd,
                                               input reg_idx_t rs, input logic [5:0] imm);
        return {op, rd, rs, imm};
    endfunction

    task automatic expect_retire(input logic [7:0] epc, input reg_idx_t erd,
                                 input logic ewe, input logic [15:0] evalue);
        expect_t e;
        e.pc    = epc;
        e.rd    = erd;
        e.we    = ewe;
        e.value = evalue;
        expect_tbl.push_back(e);
    endtask

    // Taken when the next retirement does not follow in program order
    function automatic logic branch_taken(input int k);
        logic taken;
        taken = 1'b0;
        if (k + 1 < expect_tbl.size())
            taken = expect_tbl[k+1].pc != expect_tbl[k].pc + 8'd1;
        return taken;
    endfunction

    //////////////////////////////////////////////////
    // Program and expected retirements
    //////////////////////////////////////////////////
    task automatic load_program();
        for (int a = 0; a < 256; a++)
            rom[a] = 16'(a);  // NOP with the address in the low bits
        rom[0]  = encode_imm(OP_LI,   3'd1, 3'd0, 6'd5);
        expect_retire(8'd0, 3'd1, 1'b1, 16'h0005);
        rom[1]  = encode_imm(OP_LI,   3'd2, 3'd0, 6'b111101);  // -3
        expect_retire(8'd1, 3'd2, 1'b1, 16'hfffd);
        rom[2]  = encode_reg(OP_ADD,  3'd3, 3'd1, 3'd2);        // Distances 2 and 1
        expect_retire(8'd2, 3'd3, 1'b1, 16'h0002);
        rom[3]  = encode_reg(OP_SUB,  3'd4, 3'd3, 3'd1);        // Distance 3 on r1
        expect_retire(8'd3, 3'd4, 1'b1, 16'hfffd);
        rom[4]  = encode_reg(OP_AND,  3'd5, 3'd4, 3'd1);
        expect_retire(8'd4, 3'd5, 1'b1, 16'h0005);
        rom[5]  = encode_reg(OP_OR,   3'd6, 3'd5, 3'd3);
        expect_retire(8'd5, 3'd6, 1'b1, 16'h0007);
        rom[6]  = encode_reg(OP_XOR,  3'd7, 3'd6, 3'd2);
        expect_retire(8'd6, 3'd7, 1'b1, 16'hfffa);
        rom[7]  = encode_imm(OP_ADDI, 3'd1, 3'd7, 6'd31);      // Wraps past 16 bits
        expect_retire(8'd7, 3'd1, 1'b1, 16'h0019);
        rom[8]  = encode_reg(OP_ADD,  3'd0, 3'd1, 3'd1);        // r0 target
        expect_retire(8'd8, 3'd0, 1'b0, 16'h0000);
        rom[9]  = encode_reg(OP_ADD,  3'd2, 3'd0, 3'd1);
        expect_retire(8'd9, 3'd2, 1'b1, 16'h0019);
        rom[10] = encode_imm(OP_LI,   3'd3, 3'd0, 6'd0);
        expect_retire(8'd10, 3'd3, 1'b1, 16'h0000);
        rom[11] = encode_imm(OP_BEQZ, 3'd0, 3'd3, 6'd3);       // Taken to 15
        expect_retire(8'd11, 3'd0, 1'b0, 16'h0000);
        rom[12] = encode_imm(OP_LI,   3'd4, 3'd0, 6'd1);       // Wrong path
        rom[13] = encode_imm(OP_LI,   3'd5, 3'd0, 6'd1);
        rom[14] = encode_imm(OP_LI,   3'd6, 3'd0, 6'd1);
        rom[15] = encode_imm(OP_ADDI, 3'd4, 3'd4, 6'd1);
        expect_retire(8'd15, 3'd4, 1'b1, 16'hfffe);
        rom[16] = encode_imm(OP_BEQZ, 3'd0, 3'd4, 6'd2);       // Falls through
        expect_retire(8'd16, 3'd0, 1'b0, 16'h0000);
        rom[17] = encode_reg(OP_XOR,  3'd5, 3'd5, 3'd5);
        expect_retire(8'd17, 3'd5, 1'b1, 16'h0000);
        rom[18] = encode_imm(OP_BEQZ, 3'd0, 3'd5, 6'd2);       // Taken to 21
        expect_retire(8'd18, 3'd0, 1'b0, 16'h0000);
        rom[19] = encode_imm(OP_LI,   3'd6, 3'd0, 6'd1);
        rom[20] = encode_imm(OP_LI,   3'd7, 3'd0, 6'd1);
        rom[21] = encode_reg(OP_SUB,  3'd6, 3'd6, 3'd2);
        expect_retire(8'd21, 3'd6, 1'b1, 16'hffee);
        rom[22] = encode_reg(OP_AND,  3'd7, 3'd7, 3'd6);
        expect_retire(8'd22, 3'd7, 1'b1, 16'hffea);
        rom[23] = encode_reg(OP_OR,   3'd1, 3'd7, 3'd0);
        expect_retire(8'd23, 3'd1, 1'b1, 16'hffea);
        rom[24] = encode_imm(OP_LI,   3'd0, 3'd0, 6'd7);
        expect_retire(8'd24, 3'd0, 1'b0, 16'h0000);
        rom[25] = encode_imm(OP_ADDI, 3'd2, 3'd0, 6'b111111);  // -1
        expect_retire(8'd25, 3'd2, 1'b1, 16'hffff);
        rom[26] = encode_reg(OP_NOP,  3'd0, 3'd0, 3'd0);
        expect_retire(8'd26, 3'd0, 1'b0, 16'h0000);
        rom[27] = encode_reg(OP_ADD,  3'd3, 3'd1, 3'd2);
        expect_retire(8'd27, 3'd3, 1'b1, 16'hffe9);
        rom[28] = encode_reg(OP_SUB,  3'd4, 3'd3, 3'd1);
        expect_retire(8'd28, 3'd4, 1'b1, 16'hffff);
        rom[29] = encode_reg(OP_XOR,  3'd5, 3'd4, 3'd3);
        expect_retire(8'd29, 3'd5, 1'b1, 16'h0016);
        rom[30] = encode_reg(OP_ADD,  3'd6, 3'd5, 3'd3);        // r3 three ahead
        expect_retire(8'd30, 3'd6, 1'b1, 16'hffff);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        seed = 32'h1b8f_2f29;
        rst  = 1'b1;
        hold = 1'b0;
        load_program();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        forever begin
            @(posedge clk);
            hold <= ($random(seed) & 3) == 0;  // About one cycle in four
        end
    end

    //////////////////////////////////////////////////
    // Fetch model sampled mid-cycle
    //////////////////////////////////////////////////
    always @(negedge clk) begin
        if (rst) begin
            cyc          = 0;
            accepted     = 0;
            hold_run     = 0;
            flush_cyc    = -10;
            flush_target = 0;
            pc_model     = 0;
            nxt          = 0;
        end else begin
            flush_now = cyc == flush_cyc;
            check_field("pc", 32'(pc), 32'(pc_model));
            check_field("flush", 32'(flush), 32'(flush_now));
            if (!hold && !flush_now) begin
                // The fetch right after a taken branch is on the wrong path
                if (cyc != flush_cyc - 1 && nxt < expect_tbl.size()) begin
                    check_field("fetch pc", 32'(pc), 32'(expect_tbl[nxt].pc));
                    exp_seq[nxt]   = accepted;
                    exp_fetch[nxt] = cyc;
                    exp_hold[nxt]  = hold_run;
                    if (branch_taken(nxt)) begin
                        flush_cyc    = cyc + 2;
                        flush_target = int'(expect_tbl[nxt+1].pc);
                    end
                    nxt++;
                end
                accepted++;
                pc_model++;
            end
            if (flush_now)
                pc_model = flush_target;  // Redirect
            hold_run = hold ? hold_run + 1 : 0;
            cyc++;
        end
    end

    //////////////////////////////////////////////////
    // Retirement checks
    //////////////////////////////////////////////////
    initial begin
        int waited;
        int taken_count;
        waited      = 0;
        taken_count = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (rst !== 1'b0 && waited < RESET_TIMEOUT);
        if (rst !== 1'b0)
            fail_run("Reset was never released");
        for (int k = 0; k < expect_tbl.size(); k++) begin
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (!retire_valid && waited < RETIRE_TIMEOUT);
            if (!retire_valid)
                fail_run($sformatf("Timeout: entry %0d did not retire within %0d cycles",
                                   k, RETIRE_TIMEOUT));
            if (nxt <= k)
                fail_run($sformatf("Entry %0d retired before it was fetched", k));
            if (branch_taken(k))
                taken_count++;
            check_field("retire.pc", 32'(retire.pc), 32'(expect_tbl[k].pc));
            check_field("retire.rd", 32'(retire.rd), 32'(expect_tbl[k].rd));
            check_field("retire.we", 32'(retire.we), 32'(expect_tbl[k].we));
            if (expect_tbl[k].we)
                check_field("retire.value", 32'(retire.value), 32'(expect_tbl[k].value));
            check_field("retire.tag.seq", 32'(retire.tag.seq), 32'(exp_seq[k]));
            check_field("retire.tag.fetch_cycle", 32'(retire.tag.fetch_cycle),
                        32'(exp_fetch[k]));
            check_field("retire.tag.hold_cycles", 32'(retire.tag.hold_cycles),
                        32'(exp_hold[k]));
            check_field("retire.retire_cycle", 32'(retire.retire_cycle),
                        32'(exp_fetch[k] + 3));
            check_field("flush_count", 32'(flush_count), 32'(2 * taken_count));
        end
        $display("** PASS **");
        $finish;
    end

endmodule

//--- verilog.f
verilog/cpu_pkg.sv
verilog/trace_pkg.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/result_stage.sv
verilog/pipe_trace.sv
verilog/cpu_top.sv
sim/cpu_tb.sv

//--- Makefile
# Verilator build and run of the core testbench

TOP := cpu_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
